// File: design/level_map_pkg.sv
package level_map_pkg;

    typedef logic [12:0] coord_t;  // screen or world coordinate, wraps at 8192

    localparam int MAX_PLACES = 6;
    localparam int N_CLASSES  = 9;

    // top-left corner of a placement, zero when nothing covers
    typedef struct packed {
        coord_t x;
        coord_t y;
    } origin_t;

    typedef origin_t place_table_t [MAX_PLACES];

    // priority order, also the index into hit and origin vectors
    typedef enum logic [3:0] {
        CLOUD      = 4'd0,
        LMOUNT     = 4'd1,
        SMOUNT     = 4'd2,
        TUBE_SHORT = 4'd3,
        TUBE_MID   = 4'd4,
        TUBE_TALL  = 4'd5,
        CASTLE     = 4'd6,
        FLAG       = 4'd7,
        BLOCK      = 4'd8
    } scenery_e;

    ////////////////////
    // box sizes and placement counts per class
    localparam int CLOUD_W = 64,       CLOUD_H = 48,       CLOUD_NUM = 6;
    localparam int LMOUNT_W = 160,     LMOUNT_H = 70,      LMOUNT_NUM = 5;
    localparam int SMOUNT_W = 64,      SMOUNT_H = 32,      SMOUNT_NUM = 4;
    localparam int TUBE_SHORT_W = 64,  TUBE_SHORT_H = 64,  TUBE_SHORT_NUM = 3;
    localparam int TUBE_MID_W = 64,    TUBE_MID_H = 96,    TUBE_MID_NUM = 1;
    localparam int TUBE_TALL_W = 64,   TUBE_TALL_H = 128,  TUBE_TALL_NUM = 2;
    localparam int CASTLE_W = 160,     CASTLE_H = 160,     CASTLE_NUM = 1;
    localparam int FLAG_W = 16,        FLAG_H = 288,       FLAG_NUM = 1;
    localparam int BLOCK_W = 32,       BLOCK_H = 32,       BLOCK_NUM = 1;

    ////////////////////
    // level 1-1 placements, spare slots zero
    localparam place_table_t CLOUD_PLACES = '{
        '{13'd272, 13'd66}, '{13'd624, 13'd34}, '{13'd1808, 13'd66},
        '{13'd2160, 13'd34}, '{13'd3344, 13'd66}, '{13'd6416, 13'd34}};
    localparam place_table_t LMOUNT_PLACES = '{
        '{13'd0, 13'd346}, '{13'd1536, 13'd346}, '{13'd3072, 13'd346},
        '{13'd4608, 13'd346}, '{13'd6144, 13'd346}, '{13'd0, 13'd0}};
    localparam place_table_t SMOUNT_PLACES = '{
        '{13'd754, 13'd384}, '{13'd2290, 13'd384}, '{13'd3826, 13'd384},
        '{13'd5362, 13'd384}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t TUBE_SHORT_PLACES = '{
        '{13'd896, 13'd352}, '{13'd5216, 13'd352}, '{13'd5728, 13'd352},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t TUBE_MID_PLACES = '{
        '{13'd1216, 13'd320}, '{13'd0, 13'd0}, '{13'd0, 13'd0},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t TUBE_TALL_PLACES = '{
        '{13'd1472, 13'd288}, '{13'd1824, 13'd288}, '{13'd0, 13'd0},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t CASTLE_PLACES = '{
        '{13'd6464, 13'd256}, '{13'd0, 13'd0}, '{13'd0, 13'd0},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t FLAG_PLACES = '{
        '{13'd6344, 13'd96}, '{13'd0, 13'd0}, '{13'd0, 13'd0},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};
    localparam place_table_t BLOCK_PLACES = '{
        '{13'd6336, 13'd384}, '{13'd0, 13'd0}, '{13'd0, 13'd0},
        '{13'd0, 13'd0}, '{13'd0, 13'd0}, '{13'd0, 13'd0}};  // end block below the pole

endpackage

// File: design/pixel_pkg.sv
package pixel_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // castle sprite ROM is stored as 565
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // one texel per class, same order as scenery_e
    typedef struct packed {
        rgb888_t cloud;
        rgb888_t lmount;
        rgb888_t smount;
        rgb888_t tube_short;
        rgb888_t tube_mid;
        rgb888_t tube_tall;
        rgb565_t castle;
        rgb888_t flag;
        rgb888_t block;
    } texels_t;

    localparam rgb888_t SKY_COLOR = '{r: 8'h6B, g: 8'h8C, b: 8'hFF};

endpackage

// File: design/object_locator.sv
module object_locator #(
    parameter int NUM_PLACES = 1,
    parameter int BOX_W      = 32,
    parameter int BOX_H      = 32,
    parameter level_map_pkg::place_table_t PLACES = '{default: '0}
) (
    input  logic                   Clk,
    input  logic                   rst,
    input  level_map_pkg::coord_t  world_x,
    input  level_map_pkg::coord_t  draw_y,
    output logic                   hit,
    output level_map_pkg::origin_t origin
);

    logic                   hit_next;
    level_map_pkg::origin_t origin_next;

    ////////////////////
    // box test, first table entry wins
    always_comb
    begin
        logic [13:0] x_end;  // one extra bit so x + w never wraps
        logic [13:0] y_end;
        logic        in_x;
        logic        in_y;

        hit_next    = 1'b0;
        origin_next = '0;
        // walk backwards so the lowest entry is the last to write
        for (int i = NUM_PLACES - 1; i >= 0; i--)
        begin
            x_end = {1'b0, PLACES[i].x} + 14'(BOX_W);
            y_end = {1'b0, PLACES[i].y} + 14'(BOX_H);
            in_x  = (world_x >= PLACES[i].x) && ({1'b0, world_x} < x_end);
            in_y  = (draw_y >= PLACES[i].y) && ({1'b0, draw_y} < y_end);
            if (in_x && in_y)
            begin
                hit_next    = 1'b1;
                origin_next = PLACES[i];
            end
        end
    end

    ////////////////////
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            hit    <= 1'b0;
            origin <= '0;
        end
        else
        begin
            hit    <= hit_next;
            origin <= origin_next;  // zero when no placement covers
        end
    end

endmodule

// File: design/layer_mux.sv
module layer_mux (
    input  logic                                 Clk,
    input  logic                                 rst,
    input  logic [level_map_pkg::N_CLASSES-1:0]  hit_vec,
    input  pixel_pkg::texels_t                   texels,
    output pixel_pkg::rgb888_t                   background_dout
);

    pixel_pkg::rgb888_t castle_wide;
    pixel_pkg::rgb888_t dout_next;

    // 565 to 888, low bits zero filled
    always_comb
    begin
        castle_wide.r = {texels.castle.r, 3'b000};
        castle_wide.g = {texels.castle.g, 2'b00};
        castle_wide.b = {texels.castle.b, 3'b000};
    end

    ////////////////////
    // lowest class index on top
    always_comb
    begin
        if (hit_vec[level_map_pkg::CLOUD])
            dout_next = texels.cloud;
        else if (hit_vec[level_map_pkg::LMOUNT])
            dout_next = texels.lmount;
        else if (hit_vec[level_map_pkg::SMOUNT])
            dout_next = texels.smount;
        else if (hit_vec[level_map_pkg::TUBE_SHORT])
            dout_next = texels.tube_short;
        else if (hit_vec[level_map_pkg::TUBE_MID])
            dout_next = texels.tube_mid;
        else if (hit_vec[level_map_pkg::TUBE_TALL])
            dout_next = texels.tube_tall;
        else if (hit_vec[level_map_pkg::CASTLE])
            dout_next = castle_wide;
        else if (hit_vec[level_map_pkg::FLAG])
            dout_next = texels.flag;  // pole sits in front of the end block
        else if (hit_vec[level_map_pkg::BLOCK])
            dout_next = texels.block;
        else
            dout_next = pixel_pkg::SKY_COLOR;  // nothing here, plain sky
    end

    ////////////////////
    always_ff @(posedge Clk)
    begin
        if (rst)
            background_dout <= pixel_pkg::SKY_COLOR;
        else
            background_dout <= dout_next;
    end

endmodule

// File: design/background_top.sv
module background_top (
    input  logic                    Clk,
    input  logic                    rst,
    input  level_map_pkg::coord_t   DrawX,
    input  level_map_pkg::coord_t   DrawY,
    input  level_map_pkg::coord_t   process,   // scroll offset
    input  pixel_pkg::texels_t      texels,    // from sprite ROMs, for the origins now shown
    output level_map_pkg::origin_t  origins [level_map_pkg::N_CLASSES],
    output logic                    is_castle,
    output pixel_pkg::rgb888_t      background_dout
);

    level_map_pkg::coord_t              world_x;
    logic [level_map_pkg::N_CLASSES-1:0] hit_vec;

    assign world_x = DrawX + process;  // 13 bit add, wraps past 8191

    ////////////////////
    // one locator per scenery class
    object_locator #(.NUM_PLACES(level_map_pkg::CLOUD_NUM), .BOX_W(level_map_pkg::CLOUD_W),
        .BOX_H(level_map_pkg::CLOUD_H), .PLACES(level_map_pkg::CLOUD_PLACES)) cloud_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::CLOUD]), .origin(origins[level_map_pkg::CLOUD]));

    object_locator #(.NUM_PLACES(level_map_pkg::LMOUNT_NUM), .BOX_W(level_map_pkg::LMOUNT_W),
        .BOX_H(level_map_pkg::LMOUNT_H), .PLACES(level_map_pkg::LMOUNT_PLACES)) lmount_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::LMOUNT]), .origin(origins[level_map_pkg::LMOUNT]));

    object_locator #(.NUM_PLACES(level_map_pkg::SMOUNT_NUM), .BOX_W(level_map_pkg::SMOUNT_W),
        .BOX_H(level_map_pkg::SMOUNT_H), .PLACES(level_map_pkg::SMOUNT_PLACES)) smount_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::SMOUNT]), .origin(origins[level_map_pkg::SMOUNT]));

    // three tube heights
    object_locator #(.NUM_PLACES(level_map_pkg::TUBE_SHORT_NUM),
        .BOX_W(level_map_pkg::TUBE_SHORT_W), .BOX_H(level_map_pkg::TUBE_SHORT_H),
        .PLACES(level_map_pkg::TUBE_SHORT_PLACES)) tube_short_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::TUBE_SHORT]), .origin(origins[level_map_pkg::TUBE_SHORT]));

    object_locator #(.NUM_PLACES(level_map_pkg::TUBE_MID_NUM),
        .BOX_W(level_map_pkg::TUBE_MID_W), .BOX_H(level_map_pkg::TUBE_MID_H),
        .PLACES(level_map_pkg::TUBE_MID_PLACES)) tube_mid_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::TUBE_MID]), .origin(origins[level_map_pkg::TUBE_MID]));

    object_locator #(.NUM_PLACES(level_map_pkg::TUBE_TALL_NUM),
        .BOX_W(level_map_pkg::TUBE_TALL_W), .BOX_H(level_map_pkg::TUBE_TALL_H),
        .PLACES(level_map_pkg::TUBE_TALL_PLACES)) tube_tall_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::TUBE_TALL]), .origin(origins[level_map_pkg::TUBE_TALL]));

    // end of level group
    object_locator #(.NUM_PLACES(level_map_pkg::CASTLE_NUM), .BOX_W(level_map_pkg::CASTLE_W),
        .BOX_H(level_map_pkg::CASTLE_H), .PLACES(level_map_pkg::CASTLE_PLACES)) castle_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::CASTLE]), .origin(origins[level_map_pkg::CASTLE]));

    object_locator #(.NUM_PLACES(level_map_pkg::FLAG_NUM), .BOX_W(level_map_pkg::FLAG_W),
        .BOX_H(level_map_pkg::FLAG_H), .PLACES(level_map_pkg::FLAG_PLACES)) flag_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::FLAG]), .origin(origins[level_map_pkg::FLAG]));

    object_locator #(.NUM_PLACES(level_map_pkg::BLOCK_NUM), .BOX_W(level_map_pkg::BLOCK_W),
        .BOX_H(level_map_pkg::BLOCK_H), .PLACES(level_map_pkg::BLOCK_PLACES)) block_loc (
        .Clk(Clk), .rst(rst), .world_x(world_x), .draw_y(DrawY),
        .hit(hit_vec[level_map_pkg::BLOCK]), .origin(origins[level_map_pkg::BLOCK]));

    assign is_castle = hit_vec[level_map_pkg::CASTLE];  // castle ROM is 565, tells the ROM side

    ////////////////////
    layer_mux layer_mux_inst (
        .Clk             (Clk),
        .rst             (rst),
        .hit_vec         (hit_vec),
        .texels          (texels),
        .background_dout (background_dout)
    );

endmodule

// File: bench/background_tb.sv
module background_tb;

    localparam int WORDS_PER_VEC = 7;   // x, y, scroll, hits, origin x, origin y, colour
    localparam int MAX_VEC       = 64;
    localparam int DRAIN_LIMIT   = 10;

    logic                   Clk;
    logic                   rst;
    level_map_pkg::coord_t  DrawX;
    level_map_pkg::coord_t  DrawY;
    level_map_pkg::coord_t  process;
    pixel_pkg::texels_t     texels;
    level_map_pkg::origin_t origins [level_map_pkg::N_CLASSES];
    logic                   is_castle;
    pixel_pkg::rgb888_t     background_dout;

    logic [31:0] vec_mem [WORDS_PER_VEC*MAX_VEC];
    int          vec_err [MAX_VEC];
    int          issue_cyc [MAX_VEC];   // falling edge on which each pixel went in
    int          org_q [$];             // pixels waiting for the origin check
    int          col_q [$];             // pixels waiting for the colour check
    int          n_vec;
    int          cyc;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          reset_err;
    bit          timed_out;

    background_top background_top_inst (
        .Clk             (Clk),
        .rst             (rst),
        .DrawX           (DrawX),
        .DrawY           (DrawY),
        .process         (process),
        .texels          (texels),
        .origins         (origins),
        .is_castle       (is_castle),
        .background_dout (background_dout)
    );

    initial
    begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    ////////////////////
    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp, inout int errs);
        if (got !== exp)
        begin
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
            errs++;
            errors++;
        end
    endtask

    task automatic drive_pixel(input int i);
        DrawX   = vec_mem[i*WORDS_PER_VEC][12:0];
        DrawY   = vec_mem[i*WORDS_PER_VEC+1][12:0];
        process = vec_mem[i*WORDS_PER_VEC+2][12:0];
    endtask

    // origin of the top class must match, classes not hit must read zero
    task automatic check_origins(input int i);
        int          base;
        int          top;
        logic [8:0]  exp_hit;
        logic [31:0] exp_org;
        base    = i * WORDS_PER_VEC;
        exp_hit = vec_mem[base+3][8:0];
        exp_org = {6'b0, vec_mem[base+4][12:0], vec_mem[base+5][12:0]};
        top     = -1;
        for (int c = level_map_pkg::N_CLASSES - 1; c >= 0; c--)
            if (exp_hit[c])
                top = c;
        for (int c = 0; c < level_map_pkg::N_CLASSES; c++)
        begin
            if (c == top)
                compare_value($sformatf("vector %0d origin of class %0d", i, c),
                              {6'b0, origins[c]}, exp_org, vec_err[i]);
            else if (!exp_hit[c])
                compare_value($sformatf("vector %0d origin of idle class %0d", i, c),
                              {6'b0, origins[c]}, 32'h0, vec_err[i]);
        end
        compare_value($sformatf("vector %0d is_castle", i), {31'b0, is_castle},
                      {31'b0, exp_hit[level_map_pkg::CASTLE]}, vec_err[i]);
    endtask

    task automatic check_colour(input int i);
        compare_value($sformatf("vector %0d colour", i), {8'b0, background_dout},
                      {8'b0, vec_mem[i*WORDS_PER_VEC+6][23:0]}, vec_err[i]);
        tests_run++;
        if (vec_err[i] == 0)
            $display("vector %0d ok", i);
        else
        begin
            $display("vector %0d failed with %0d mismatches", i, vec_err[i]);
            tests_failed++;
        end
    endtask

    ////////////////////
    initial
    begin
        int next;
        int drain;
        int idx;

        rst          = 1'b1;
        DrawX        = '0;
        DrawY        = '0;
        process      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_err    = 0;
        timed_out    = 1'b0;
        // texel of class n is 0n0n0n, castle is magenta in 565
        texels.cloud      = 24'h000000;
        texels.lmount     = 24'h010101;
        texels.smount     = 24'h020202;
        texels.tube_short = 24'h030303;
        texels.tube_mid   = 24'h040404;
        texels.tube_tall  = 24'h050505;
        texels.castle     = 16'hF81F;
        texels.flag       = 24'h070707;
        texels.block      = 24'h080808;
        for (int k = 0; k < WORDS_PER_VEC*MAX_VEC; k++)
            vec_mem[k] = 32'hFFFF_FFFF;   // end marker
        for (int k = 0; k < MAX_VEC; k++)
            vec_err[k] = 0;
        $readmemh("bench/background_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec*WORDS_PER_VEC] !== 32'hFFFF_FFFF)
            n_vec++;
        if (n_vec == 0)
        begin
            $display("no vectors were read from bench/background_vectors.txt");
            errors++;
        end

        repeat (5) @(posedge Clk);
        @(negedge Clk);
        // still in reset, nothing in flight
        compare_value("reset colour", {8'b0, background_dout}, 32'h006B8CFF, reset_err);
        compare_value("reset is_castle", {31'b0, is_castle}, 32'h0, reset_err);
        for (int c = 0; c < level_map_pkg::N_CLASSES; c++)
            compare_value($sformatf("reset origin of class %0d", c), {6'b0, origins[c]},
                          32'h0, reset_err);
        tests_run++;
        if (reset_err == 0)
            $display("reset state ok");
        else
        begin
            $display("reset state failed with %0d mismatches", reset_err);
            tests_failed++;
        end
        rst = 1'b0;

        ////////////////////
        // back to back stream, one pixel per falling edge
        // origins show up one edge after a pixel goes in, colour one edge later
        next  = 0;
        drain = 0;
        cyc   = 0;
        while (!timed_out && (next < n_vec || org_q.size() > 0 || col_q.size() > 0))
        begin
            @(negedge Clk);
            cyc++;
            if (col_q.size() > 0 && issue_cyc[col_q[0]] + 2 == cyc)
            begin
                idx = col_q.pop_front();
                check_colour(idx);
            end
            if (org_q.size() > 0 && issue_cyc[org_q[0]] + 1 == cyc)
            begin
                idx = org_q.pop_front();
                check_origins(idx);
                col_q.push_back(idx);
            end
            if (next < n_vec)
            begin
                drive_pixel(next);
                issue_cyc[next] = cyc;
                org_q.push_back(next);
                next++;
            end
            else
            begin
                DrawX   = '0;
                DrawY   = '0;
                process = '0;
                drain++;
                if (drain > DRAIN_LIMIT)
                begin
                    $display("results still missing after %0d idle cycles", DRAIN_LIMIT);
                    timed_out = 1'b1;
                end
            end
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: bench/background_vectors.txt
// DrawX DrawY process hit_vec origin_x origin_y colour, all hex
// hit_vec bits follow scenery_e, origin belongs to the highest priority class hit
014 190 0000 002 0000 015A 010101
12C 050 0000 001 0110 0042 000000
110 042 0000 001 0110 0042 000000
150 050 0000 000 0000 0000 6B8CFF
12C 072 0000 000 0000 0000 6B8CFF
1F4 032 0000 000 0000 0000 6B8CFF
050 190 02BC 004 02F2 0180 020202
028 17C 0370 008 0380 0160 030303
032 15E 04B0 010 04C0 0140 040404
064 12C 0578 020 05C0 0120 050505
018 120 0708 020 0720 0120 050505
058 12C 0708 000 0000 0000 6B8CFF
032 1A0 0708 000 0000 0000 6B8CFF
064 168 05DC 002 0600 015A 010101
096 12C 1900 040 1940 0100 F800F8
040 100 1900 040 1940 0100 F800F8
0E0 12C 1900 000 0000 0000 6B8CFF
01E 028 1900 001 1910 0022 000000
032 0C8 189C 080 18C8 0060 070707
028 190 189C 100 18C0 0180 080808
032 180 189C 100 18C0 0180 080808
064 190 1FD6 002 0000 015A 010101

// File: vlog.f
design/level_map_pkg.sv
design/pixel_pkg.sv
design/object_locator.sv
design/layer_mux.sv
design/background_top.sv
bench/background_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = background_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
